// File: Bender.yml
package:
  name: voice_recorder

sources:
  - src/audio_mem_pkg.sv
  - src/io_port_pkg.sv
  - src/io_port_regs.sv
  - src/codec_strobe_sync.sv
  - src/slot_transfer_engine.sv
  - src/voice_recorder_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_voice_recorder.sv

// File: src/audio_mem_pkg.sv
package audio_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sample memory types
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] sample_t;
	typedef logic [6:0]  mem_addr_t;
	typedef logic [2:0]  slot_idx_t;

	// Slot geometry, five slots of 16 words packed from address 0
	localparam int unsigned NUM_SLOTS  = 5;
	localparam int unsigned SLOT_WORDS = 16;
	localparam mem_addr_t   MEM_TOP    = 7'd79;

	//////////////////////////////////////////////////////////////////////
	// Memory port
	//////////////////////////////////////////////////////////////////////

	// Request side, driven by the transfer engine
	// wr_en writes wdata at addr on the clock edge
	// rd_req is held until rd_present, then rd_ack pulses once
	typedef struct packed {
		logic      wr_en;
		logic      rd_req;
		logic      rd_ack;
		mem_addr_t addr;
		sample_t   wdata;
	} mem_req_t;

	// Response side
	// rd_data is valid while rd_present is high
	typedef struct packed {
		logic    rd_present;
		sample_t rd_data;
	} mem_rsp_t;

endpackage

// File: src/codec_strobe_sync.sv
`timescale 1ns/1ps

module codec_strobe_sync (
	input  logic clk1,
	input  logic pb_reset,
	input  logic s_req,
	input  logic s_end,
	output logic req_pulse,
	output logic end_pulse
);

	// Bit 0 carries s_req, bit 1 carries s_end
	logic [1:0] meta;
	logic [1:0] sync;
	logic [1:0] prev;
	logic [1:0] pulse;

	//////////////////////////////////////////////////////////////////////
	// Two-flop synchronizer and rising edge detect
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			meta  <= 2'b00;
			sync  <= 2'b00;
			prev  <= 2'b00;
			pulse <= 2'b00;
		end else begin
			// First stage may go metastable
			meta  <= {s_end, s_req};
			sync  <= meta;
			prev  <= sync;
			// One cycle per codec strobe, third edge after it rises
			pulse <= sync & ~prev;
		end
	end

	assign req_pulse = pulse[0];
	assign end_pulse = pulse[1];

endmodule

// File: src/io_port_pkg.sv
package io_port_pkg;

	//////////////////////////////////////////////////////////////////////
	// Port bus types
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] port_id_t;
	typedef logic [7:0] port_data_t;

	// Input ports
	localparam port_id_t PORT_SWITCHES   = 8'h00;
	localparam port_id_t PORT_BTN_UP     = 8'h06;
	localparam port_id_t PORT_BTN_DOWN   = 8'h07;
	localparam port_id_t PORT_BTN_SELECT = 8'h08;
	localparam port_id_t PORT_BTN_BACK   = 8'h09;
	localparam port_id_t PORT_BTN_PAUSE  = 8'h0A;
	localparam port_id_t PORT_DONE       = 8'h0F;

	// Output ports
	localparam port_id_t PORT_VOLUME  = 8'h04;
	localparam port_id_t PORT_REC_ARM = 8'h05;
	localparam port_id_t PORT_MODE    = 8'h0B;
	localparam port_id_t PORT_SLOT    = 8'h0C;

	typedef logic [3:0] volume_t;

	// Volume step codes written to PORT_VOLUME
	localparam port_data_t VOL_UP_CODE   = 8'd1;
	localparam port_data_t VOL_DOWN_CODE = 8'd2;
	localparam volume_t    VOL_MIN       = 4'd1;
	localparam volume_t    VOL_MAX       = 4'd15;
	localparam volume_t    VOL_RESET     = 4'd1;

	// Encodings match the values the processor writes to PORT_MODE
	typedef enum logic [2:0] {
		MODE_MAIN    = 3'd0,
		MODE_PLAY    = 3'd1,
		MODE_RECORD  = 3'd2,
		MODE_DEL_ONE = 3'd3,
		MODE_DEL_ALL = 3'd4,
		MODE_VOLUME  = 3'd5
	} mode_e;

	typedef struct packed {
		port_id_t   port_id;
		port_data_t out_port;
		logic       write_strobe;
		logic       read_strobe;
	} port_bus_t;

	// Start is a single-cycle pulse
	typedef struct packed {
		mode_e                   mode;
		audio_mem_pkg::slot_idx_t slot;
		logic                    rec_armed;
		logic                    start;
	} xfer_ctrl_t;

endpackage

// File: src/io_port_regs.sv
`timescale 1ns/1ps

module io_port_regs
	import io_port_pkg::*;
	import audio_mem_pkg::*;
(
	input  logic       clk1,
	input  logic       pb_reset,
	input  port_bus_t  bus,
	input  logic [3:0] switches,
	input  logic [4:0] buttons,
	input  logic       xfer_done,
	output port_data_t in_port,
	output xfer_ctrl_t ctrl,
	output volume_t    volume,
	output logic [7:0] led
);

	mode_e      mode_q;
	mode_e      mode_d;
	slot_idx_t  slot_q;
	slot_idx_t  slot_d;
	logic       rec_armed_q;
	logic       rec_armed_d;
	logic       start_q;
	logic       start_d;
	volume_t    volume_q;
	volume_t    volume_d;
	logic       slot_mode;
	logic [7:0] led_d;
	port_data_t read_d;

	// Slot writes only count in modes that work on one slot
	assign slot_mode = (mode_q == MODE_PLAY) || (mode_q == MODE_RECORD) ||
		(mode_q == MODE_DEL_ONE);

	//////////////////////////////////////////////////////////////////////
	// Port write decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		mode_d      = mode_q;
		slot_d      = slot_q;
		rec_armed_d = rec_armed_q;
		volume_d    = volume_q;
		start_d     = 1'b0;
		if (bus.write_strobe) begin
			case (bus.port_id)
				PORT_MODE: begin
					// Codes above volume are not modes
					if (bus.out_port <= port_data_t'(MODE_VOLUME)) begin
						mode_d  = mode_e'(bus.out_port[2:0]);
						start_d = (bus.out_port == port_data_t'(MODE_DEL_ALL));
					end
				end
				PORT_SLOT: begin
					if (slot_mode && (bus.out_port < NUM_SLOTS)) begin
						slot_d  = slot_idx_t'(bus.out_port);
						start_d = 1'b1;
					end
				end
				PORT_REC_ARM: begin
					rec_armed_d = (bus.out_port == 8'd1);
				end
				PORT_VOLUME: begin
					// One step per write, saturating at both ends
					if (mode_q == MODE_VOLUME) begin
						if ((bus.out_port == VOL_UP_CODE) && (volume_q < VOL_MAX))
							volume_d = volume_q + 4'd1;
						else if ((bus.out_port == VOL_DOWN_CODE) && (volume_q > VOL_MIN))
							volume_d = volume_q - 4'd1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// LED decode from the next mode so it lines up with the mode register
	always_comb begin
		led_d = 8'h00;
		case (mode_d)
			MODE_MAIN:    led_d[0] = 1'b1;
			MODE_PLAY:    led_d[1] = 1'b1;
			MODE_RECORD:  led_d[2] = rec_armed_d;
			MODE_DEL_ALL: led_d[3] = 1'b1;
			MODE_DEL_ONE: led_d[4] = 1'b1;
			MODE_VOLUME:  led_d[5] = 1'b1;
			default:      led_d = 8'h00;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux, single-bit ports land in the LSB
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (bus.port_id)
			PORT_SWITCHES:   read_d = {4'h0, switches};
			PORT_BTN_UP:     read_d = {7'h00, buttons[0]};
			PORT_BTN_DOWN:   read_d = {7'h00, buttons[1]};
			PORT_BTN_SELECT: read_d = {7'h00, buttons[2]};
			PORT_BTN_BACK:   read_d = {7'h00, buttons[3]};
			PORT_BTN_PAUSE:  read_d = {7'h00, buttons[4]};
			PORT_DONE:       read_d = {7'h00, xfer_done};
			default:         read_d = 8'h00;
		endcase
	end

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			mode_q      <= MODE_MAIN;
			slot_q      <= '0;
			rec_armed_q <= 1'b0;
			start_q     <= 1'b0;
			volume_q    <= VOL_RESET;
			led         <= 8'h01;
			in_port     <= 8'h00;
		end else begin
			mode_q      <= mode_d;
			slot_q      <= slot_d;
			rec_armed_q <= rec_armed_d;
			start_q     <= start_d;
			volume_q    <= volume_d;
			led         <= led_d;
			in_port     <= read_d;
		end
	end

	assign ctrl = '{mode: mode_q, slot: slot_q, rec_armed: rec_armed_q, start: start_q};
	assign volume = volume_q;

	// The processor never reads and writes in the same cycle
	a_strobe_excl: assert property (@(posedge clk1) disable iff (pb_reset)
		!(bus.read_strobe && bus.write_strobe));

endmodule

// File: src/slot_transfer_engine.sv
`timescale 1ns/1ps

module slot_transfer_engine
	import io_port_pkg::*;
	import audio_mem_pkg::*;
(
	input  logic       clk1,
	input  logic       pb_reset,
	input  xfer_ctrl_t ctrl,
	input  logic       req_pulse,
	input  logic       end_pulse,
	input  sample_t    audio_in,
	input  mem_rsp_t   mem_rsp,
	output mem_req_t   mem_req,
	output sample_t    audio_out,
	output logic       xfer_done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_HOLD_SAMPLE,
		ST_WRITE_WORD,
		ST_FINISHED
	} state_e;

	state_e    state;
	mode_e     run_mode;
	mem_addr_t addr;
	mem_addr_t end_addr;
	mem_addr_t slot_base;
	mem_addr_t slot_end;
	sample_t   sample_q;
	logic      rd_ack_q;
	logic      done_q;
	logic      mode_left;
	logic      write_ok;
	logic      last_word;

	// Slot geometry
	assign slot_base = mem_addr_t'(ctrl.slot * SLOT_WORDS);
	assign slot_end  = slot_base + mem_addr_t'(SLOT_WORDS - 1);

	// Leaving the running mode aborts the transfer
	assign mode_left = (state != ST_IDLE) && (ctrl.mode != run_mode);
	// Record only writes while armed, erase always writes
	assign write_ok  = end_pulse && ((run_mode != MODE_RECORD) || ctrl.rec_armed);
	assign last_word = (addr == end_addr);

	//////////////////////////////////////////////////////////////////////
	// Transfer FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk1 or posedge pb_reset) begin
		if (pb_reset) begin
			state     <= ST_IDLE;
			run_mode  <= MODE_MAIN;
			addr      <= '0;
			end_addr  <= '0;
			rd_ack_q  <= 1'b0;
			done_q    <= 1'b0;
			audio_out <= '0;
		end else begin
			rd_ack_q <= 1'b0;
			if (ctrl.start) begin
				done_q   <= 1'b0;
				run_mode <= ctrl.mode;
				if (ctrl.mode == MODE_DEL_ALL) begin
					addr     <= '0;
					end_addr <= MEM_TOP;
				end else begin
					addr     <= slot_base;
					end_addr <= slot_end;
				end
				case (ctrl.mode)
					MODE_PLAY:                              state <= ST_FETCH;
					MODE_RECORD, MODE_DEL_ONE, MODE_DEL_ALL: state <= ST_HOLD_SAMPLE;
					default:                                state <= ST_IDLE;
				endcase
			end else if (mode_left) begin
				state <= ST_IDLE;
			end else begin
				case (state)
					ST_FETCH: begin
						// Word is latched this edge, ack follows
						if (mem_rsp.rd_present) begin
							rd_ack_q <= 1'b1;
							state    <= ST_HOLD_SAMPLE;
						end
					end
					ST_HOLD_SAMPLE: begin
						if (run_mode == MODE_PLAY) begin
							if (req_pulse) begin
								audio_out <= sample_q;
								if (last_word) begin
									done_q <= 1'b1;
									state  <= ST_FINISHED;
								end else begin
									addr  <= addr + 7'd1;
									state <= ST_FETCH;
								end
							end
						end else if (write_ok) begin
							state <= ST_WRITE_WORD;
						end
					end
					ST_WRITE_WORD: begin
						if (last_word) begin
							done_q <= 1'b1;
							state  <= ST_FINISHED;
						end else begin
							addr  <= addr + 7'd1;
							state <= ST_HOLD_SAMPLE;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Fetched word in play, captured or zero word in the write modes
	always_ff @(posedge clk1) begin
		if ((state == ST_FETCH) && mem_rsp.rd_present)
			sample_q <= mem_rsp.rd_data;
		else if ((state == ST_HOLD_SAMPLE) && (run_mode != MODE_PLAY) && write_ok)
			sample_q <= (run_mode == MODE_RECORD) ? audio_in : '0;
	end

	always_comb begin
		mem_req.wr_en  = (state == ST_WRITE_WORD);
		mem_req.rd_req = (state == ST_FETCH);
		mem_req.rd_ack = rd_ack_q;
		mem_req.addr   = addr;
		mem_req.wdata  = sample_q;
	end

	assign xfer_done = done_q;

	a_no_rd_wr: assert property (@(posedge clk1) disable iff (pb_reset)
		!(mem_req.wr_en && mem_req.rd_req));

	a_wr_in_range: assert property (@(posedge clk1) disable iff (pb_reset)
		mem_req.wr_en |-> (mem_req.addr <= MEM_TOP));

endmodule

// File: src/voice_recorder_top.sv
`timescale 1ns/1ps

module voice_recorder_top
	import io_port_pkg::*;
	import audio_mem_pkg::*;
(
	input  logic       clk1,
	input  logic       pb_reset,
	input  port_bus_t  bus,
	input  logic [3:0] switches,
	input  logic [4:0] buttons,
	input  logic       s_req,
	input  logic       s_end,
	input  sample_t    audio_in,
	input  mem_rsp_t   mem_rsp,
	output port_data_t in_port,
	output mem_req_t   mem_req,
	output sample_t    audio_out,
	output volume_t    volume,
	output logic [7:0] led
);

	xfer_ctrl_t ctrl;
	logic       xfer_done;
	logic       req_pulse;
	logic       end_pulse;

	//////////////////////////////////////////////////////////////////////
	// Processor port registers
	//////////////////////////////////////////////////////////////////////

	io_port_regs u_regs (
		.clk1      (clk1),
		.pb_reset  (pb_reset),
		.bus       (bus),
		.switches  (switches),
		.buttons   (buttons),
		.xfer_done (xfer_done),
		.in_port   (in_port),
		.ctrl      (ctrl),
		.volume    (volume),
		.led       (led)
	);

	// Codec strobes arrive from the audio clock domain
	codec_strobe_sync u_sync (
		.clk1      (clk1),
		.pb_reset  (pb_reset),
		.s_req     (s_req),
		.s_end     (s_end),
		.req_pulse (req_pulse),
		.end_pulse (end_pulse)
	);

	slot_transfer_engine u_engine (
		.clk1      (clk1),
		.pb_reset  (pb_reset),
		.ctrl      (ctrl),
		.req_pulse (req_pulse),
		.end_pulse (end_pulse),
		.audio_in  (audio_in),
		.mem_rsp   (mem_rsp),
		.mem_req   (mem_req),
		.audio_out (audio_out),
		.xfer_done (xfer_done)
	);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk1,
	output logic pb_reset
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYCLES   = 3;

	initial begin
		clk1 = 1'b0;
		forever #(HALF_PERIOD_NS) clk1 = ~clk1;
	end

	// Reset released on a falling edge, like every other input
	initial begin
		pb_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk1);
		@(negedge clk1);
		pb_reset = 1'b0;
	end

endmodule

// File: verification/tb_voice_recorder.sv
`timescale 1ns/1ps

module tb_voice_recorder
	import io_port_pkg::*;
	import audio_mem_pkg::*;
();

	// Per-test cycle budgets summed for the watchdog
	localparam int CLK_PERIOD_NS = 40;
	localparam int BUDGET_CYCLES = 100 + 400 + 600 + 1400 + 300;
	localparam int STROBE_HIGH   = 2;
	localparam int STROBE_LOW    = 4;

	logic       clk1;
	logic       pb_reset;
	port_bus_t  bus;
	logic [3:0] switches;
	logic [4:0] buttons;
	logic       s_req;
	logic       s_end;
	sample_t    audio_in;
	mem_rsp_t   mem_rsp;
	port_data_t in_port;
	mem_req_t   mem_req;
	sample_t    audio_out;
	volume_t    volume;
	logic [7:0] led;

	integer     seed;
	int         error_count;
	sample_t    mem [0:MEM_TOP];
	mem_addr_t  wr_addr_log[$];
	sample_t    wr_data_log[$];
	sample_t    rec_samples[$];
	int         fetch_count;
	int         high_writes;
	mem_addr_t  last_fetch_addr;
	logic       rd_pending;
	int         rd_wait;

	tb_clock_gen u_clk (.clk1(clk1), .pb_reset(pb_reset));

	voice_recorder_top u_dut (
		.clk1      (clk1),
		.pb_reset  (pb_reset),
		.bus       (bus),
		.switches  (switches),
		.buttons   (buttons),
		.s_req     (s_req),
		.s_end     (s_end),
		.audio_in  (audio_in),
		.mem_rsp   (mem_rsp),
		.in_port   (in_port),
		.mem_req   (mem_req),
		.audio_out (audio_out),
		.volume    (volume),
		.led       (led)
	);

	//////////////////////////////////////////////////////////////////////
	// Sample memory model
	//////////////////////////////////////////////////////////////////////

	function automatic sample_t fill_word(input int unsigned a);
		return sample_t'(16'h5a00 ^ (a * 16'h0203));
	endfunction

	always @(negedge clk1) begin
		if (mem_req.wr_en) begin
			wr_addr_log.push_back(mem_req.addr);
			wr_data_log.push_back(mem_req.wdata);
			if (mem_req.addr <= MEM_TOP)
				mem[mem_req.addr] = mem_req.wdata;
			else
				high_writes++;
		end
		if (mem_req.rd_ack || !mem_req.rd_req) begin
			if (mem_req.rd_ack)
				fetch_count++;
			mem_rsp.rd_present = 1'b0;
			rd_pending = 1'b0;
		end else if (!mem_rsp.rd_present) begin
			// Random answer delay of 1 to 4 cycles
			if (!rd_pending) begin
				rd_pending = 1'b1;
				rd_wait = 1 + ($random(seed) & 3);
			end
			rd_wait--;
			if (rd_wait == 0) begin
				rd_pending = 1'b0;
				mem_rsp.rd_present = 1'b1;
				mem_rsp.rd_data = mem[mem_req.addr];
				last_fetch_addr = mem_req.addr;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus, codec and check helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic write_port(input port_id_t id, input port_data_t data);
		@(negedge clk1);
		bus.port_id = id;
		bus.out_port = data;
		bus.write_strobe = 1'b1;
		@(negedge clk1);
		bus.write_strobe = 1'b0;
	endtask

	// in_port is registered and valid one edge after port_id
	task automatic read_port(input port_id_t id, output port_data_t data);
		@(negedge clk1);
		bus.port_id = id;
		bus.read_strobe = 1'b1;
		@(negedge clk1);
		bus.read_strobe = 1'b0;
		data = in_port;
	endtask

	task automatic codec_strobe(input logic is_end, input sample_t sample);
		@(negedge clk1);
		audio_in = sample;
		if (is_end)
			s_end = 1'b1;
		else
			s_req = 1'b1;
		repeat (STROBE_HIGH) @(negedge clk1);
		s_end = 1'b0;
		s_req = 1'b0;
		repeat (STROBE_LOW) @(negedge clk1);
	endtask

	// Waits on the write log or the fetch count of the memory model
	task automatic wait_for_memory(input logic on_writes, input int count);
		int n;
		n = 0;
		while (((on_writes ? wr_addr_log.size() : fetch_count) < count) && (n < 30)) begin
			@(negedge clk1);
			n++;
		end
		assert ((on_writes ? wr_addr_log.size() : fetch_count) >= count) else begin
			$display("memory access %0d never arrived", count);
			error_count++;
		end
	endtask

	task automatic wait_done();
		port_data_t d;
		int n;
		d = 8'h00;
		n = 0;
		while (!d[0] && (n < 20)) begin
			read_port(PORT_DONE, d);
			n++;
		end
		assert (d[0]) else begin
			$display("done never went high");
			error_count++;
		end
	endtask

	// Sends strobes until count writes are seen and then two spare strobes
	task automatic run_writes(input int count, input logic random_data);
		sample_t smp;
		int i;
		for (i = 0; i < count + 2; i++) begin
			smp = random_data ? sample_t'($random(seed)) : 16'hffff;
			if (random_data && (i < count))
				rec_samples.push_back(smp);
			codec_strobe(1'b1, smp);
			if (i < count)
				wait_for_memory(1'b1, i + 1);
		end
		check_value("write_count", wr_addr_log.size(), count);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_port_reads();
		port_id_t btn_ports[5] = '{PORT_BTN_UP, PORT_BTN_DOWN, PORT_BTN_SELECT,
			PORT_BTN_BACK, PORT_BTN_PAUSE};
		port_data_t d;
		check_value("led", led, 8'h01);
		check_value("volume", volume, VOL_RESET);
		check_value("audio_out", audio_out, 16'h0000);
		check_value("wr_en", mem_req.wr_en, 1'b0);
		check_value("rd_req", mem_req.rd_req, 1'b0);
		check_value("rd_ack", mem_req.rd_ack, 1'b0);
		read_port(PORT_SWITCHES, d);
		check_value("in_port switches", d, {4'h0, switches});
		for (int j = 0; j < 5; j++) begin
			read_port(btn_ports[j], d);
			check_value("in_port button", d, {7'h00, buttons[j]});
		end
		read_port(PORT_DONE, d);
		check_value("in_port done", d, 8'h00);
		read_port(8'h03, d);
		check_value("in_port unlisted", d, 8'h00);
	endtask

	task automatic test_record();
		write_port(PORT_MODE, port_data_t'(MODE_RECORD));
		write_port(PORT_REC_ARM, 8'd1);
		check_value("led", led, 8'h04);
		wr_addr_log.delete();
		wr_data_log.delete();
		rec_samples.delete();
		write_port(PORT_SLOT, 8'd2);
		run_writes(SLOT_WORDS, 1'b1);
		for (int i = 0; i < wr_addr_log.size() && i < SLOT_WORDS; i++) begin
			check_value("wr addr", wr_addr_log[i], 2 * SLOT_WORDS + i);
			check_value("wr data", wr_data_log[i], rec_samples[i]);
		end
		wait_done();
	endtask

	task automatic test_playback();
		port_data_t d;
		write_port(PORT_MODE, port_data_t'(MODE_PLAY));
		check_value("led", led, 8'h02);
		fetch_count = 0;
		write_port(PORT_SLOT, 8'd2);
		read_port(PORT_DONE, d);
		check_value("in_port done", d, 8'h00);
		for (int k = 0; k < SLOT_WORDS; k++) begin
			wait_for_memory(1'b0, k + 1);
			check_value("fetch addr", last_fetch_addr, 2 * SLOT_WORDS + k);
			// Done stays low until the last word is played
			if (k == SLOT_WORDS - 1) begin
				read_port(PORT_DONE, d);
				check_value("in_port done", d, 8'h00);
			end
			codec_strobe(1'b0, 16'h0000);
			check_value("audio_out", audio_out, rec_samples[k]);
		end
		wait_done();
	endtask

	task automatic test_erase();
		sample_t exp;
		write_port(PORT_MODE, port_data_t'(MODE_DEL_ONE));
		check_value("led", led, 8'h10);
		wr_addr_log.delete();
		wr_data_log.delete();
		write_port(PORT_SLOT, 8'd1);
		run_writes(SLOT_WORDS, 1'b0);
		for (int i = 0; i < wr_addr_log.size() && i < SLOT_WORDS; i++) begin
			check_value("wr addr", wr_addr_log[i], SLOT_WORDS + i);
			check_value("wr data", wr_data_log[i], 16'h0000);
		end
		wait_done();
		// Slots other than 1 keep their contents
		for (int a = 0; a <= MEM_TOP; a++) begin
			if (a / SLOT_WORDS != 1) begin
				exp = (a / SLOT_WORDS == 2) ? rec_samples[a - 2 * SLOT_WORDS] : fill_word(a);
				check_value("mem word", mem[a], exp);
			end
		end
		wr_addr_log.delete();
		wr_data_log.delete();
		write_port(PORT_MODE, port_data_t'(MODE_DEL_ALL));
		check_value("led", led, 8'h08);
		run_writes(MEM_TOP + 1, 1'b0);
		for (int i = 0; i < wr_addr_log.size() && i <= MEM_TOP; i++) begin
			check_value("wr addr", wr_addr_log[i], i);
			check_value("wr data", wr_data_log[i], 16'h0000);
		end
		check_value("writes above top", high_writes, 0);
		wait_done();
	endtask

	task automatic test_volume();
		write_port(PORT_MODE, port_data_t'(MODE_VOLUME));
		check_value("led", led, 8'h20);
		repeat (16) write_port(PORT_VOLUME, VOL_UP_CODE);
		check_value("volume", volume, VOL_MAX);
		// Main mode ignores volume writes
		write_port(PORT_MODE, port_data_t'(MODE_MAIN));
		write_port(PORT_VOLUME, VOL_DOWN_CODE);
		check_value("volume", volume, VOL_MAX);
		write_port(PORT_MODE, port_data_t'(MODE_VOLUME));
		repeat (16) write_port(PORT_VOLUME, VOL_DOWN_CODE);
		check_value("volume", volume, VOL_MIN);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence, watchdog and summary
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h73ec_0a6a;
		error_count = 0;
		fetch_count = 0;
		high_writes = 0;
		rd_pending = 1'b0;
		rd_wait = 0;
		last_fetch_addr = '0;
		bus = '0;
		switches = 4'ha;
		buttons = 5'b10110;
		s_req = 1'b0;
		s_end = 1'b0;
		audio_in = '0;
		mem_rsp = '0;
		for (int a = 0; a <= MEM_TOP; a++)
			mem[a] = fill_word(a);
		@(negedge pb_reset);
		test_port_reads();
		test_record();
		test_playback();
		test_erase();
		test_volume();
		$display("check errors: %0d", error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(BUDGET_CYCLES * CLK_PERIOD_NS);
		$display("watchdog expired before the tests finished, errors so far: %0d",
			error_count);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: voice_recorder_top.f
src/audio_mem_pkg.sv
src/io_port_pkg.sv
src/io_port_regs.sv
src/codec_strobe_sync.sv
src/slot_transfer_engine.sv
src/voice_recorder_top.sv
verification/tb_clock_gen.sv
verification/tb_voice_recorder.sv
